// ==== hdl/hv_reg_pkg.sv ====
// Register map, bank access types and the frame CRC rule shared by the SPI, arbiter and bank
`default_nettype none

package hv_reg_pkg;

    typedef logic [6:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    typedef logic [7:0] reg_crc_t;

    //==================================================
    // register map
    //==================================================
    localparam reg_addr_t ADDR_MODE      = 7'h00;
    localparam reg_addr_t ADDR_CFG_FIRST = 7'h01;
    localparam reg_addr_t ADDR_CFG_LAST  = 7'h06;
    localparam reg_addr_t ADDR_STATUS1   = 7'h10;  // sticky and write one to clear
    localparam reg_addr_t ADDR_STATUS2   = 7'h11;  // read-only live faults
    localparam int        NUM_CFG        = 6;

    // one bank access as issued by a peer
    typedef struct packed {
        logic      wr;
        reg_addr_t addr;
        reg_data_t data;
        reg_crc_t  crc;    // frame crc kept with config writes
    } reg_req_t;

    typedef struct packed {
        reg_data_t data;
        reg_crc_t  crc;
    } reg_rsp_t;

    // msb-first crc-8 with poly 0x07 and zero init over {wr, addr, data}
    function automatic reg_crc_t crc8(input logic [15:0] din);
        reg_crc_t crc;
        crc = '0;
        for (int i = 15; i >= 0; i--) begin
            if (crc[7] ^ din[i]) begin
                crc = {crc[6:0], 1'b0} ^ 8'h07;
            end else begin
                crc = {crc[6:0], 1'b0};
            end
        end
        return crc;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/hv_ctrl_pkg.sv ====
// Driver-side types for the fault inputs, the configuration outputs and the mode register
`default_nettype none

package hv_ctrl_pkg;

    typedef logic [7:0] cfg_sel_t;

    typedef struct packed {
        logic uv;
        logic ov;
        logic ot;
        logic oc;
        logic desat;
        logic scp;
    } hv_fault_t;

    // address 1 sits in the top byte
    typedef struct packed {
        cfg_sel_t src_sel;
        cfg_sel_t snk_sel;
        cfg_sel_t desat_sel;
        cfg_sel_t oc_sel;
        cfg_sel_t sc_sel;
        cfg_sel_t dvdt_sel;
    } hv_cfg_t;

    typedef struct packed {
        logic [6:0] rsvd;        // always 0
        logic       crc_bypass;  // config writes skip the frame crc check
    } hv_mode_t;

endpackage

`default_nettype wire

// ==== hdl/hv_spi_slv.sv ====
// SPI mode 0 slave that checks 24-bit frames and turns accepted ones into bank requests
`default_nettype none

module hv_spi_slv import hv_reg_pkg::*; import hv_ctrl_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_spi_sclk,
    input  logic     i_spi_csb,
    input  logic     i_spi_mosi,
    output logic     o_spi_miso,
    input  hv_mode_t i_mode,
    output logic     o_req_vld,
    output reg_req_t o_req,
    input  logic     i_ack,
    input  reg_rsp_t i_rsp,
    output logic     o_spi_err
);

    logic [2:0]  sclk_q;
    logic [2:0]  csb_q;
    logic [1:0]  mosi_q;
    logic        sclk_rise;
    logic        sclk_fall;
    logic        csb_rise;
    logic [4:0]  bit_cnt;
    logic [23:0] rx_sr;
    logic [23:0] tx_sr;
    logic [23:0] rsp_word;
    logic        frame_wr;
    reg_addr_t   frame_addr;
    reg_data_t   frame_data;
    reg_crc_t    frame_crc;
    logic        crc_ok;
    logic        bypass_ok;
    logic        frame_ok;

    //==================================================
    // bus synchronizers
    //==================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            sclk_q <= '0;
            csb_q  <= '1;  // idle high, no false frame end
            mosi_q <= '0;
        end else begin
            sclk_q <= {sclk_q[1:0], i_spi_sclk};
            csb_q  <= {csb_q[1:0], i_spi_csb};
            mosi_q <= {mosi_q[0], i_spi_mosi};
        end
    end

    assign sclk_rise = !csb_q[1] && (sclk_q[2:1] == 2'b01);
    assign sclk_fall = !csb_q[1] && (sclk_q[2:1] == 2'b10);
    assign csb_rise  = (csb_q[2:1] == 2'b01);

    //==================================================
    // receive and frame check
    //==================================================
    assign {frame_wr, frame_addr, frame_data, frame_crc} = rx_sr;
    assign crc_ok    = (crc8(rx_sr[23:8]) == frame_crc);
    assign bypass_ok = frame_wr && i_mode.crc_bypass &&
                       (frame_addr >= ADDR_CFG_FIRST) && (frame_addr <= ADDR_CFG_LAST);
    assign frame_ok  = (bit_cnt == 5'd24) && (crc_ok || bypass_ok);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            bit_cnt <= '0;
        end else if (csb_q[1]) begin
            bit_cnt <= '0;
        end else if (sclk_rise && (bit_cnt != 5'd31)) begin
            bit_cnt <= bit_cnt + 5'd1;  // saturates so long frames stay rejected
        end
    end

    always_ff @(posedge i_clk) begin
        if (sclk_rise) begin
            rx_sr <= {rx_sr[22:0], mosi_q[1]};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_req_vld <= 1'b0;
            o_spi_err <= 1'b0;
        end else begin
            o_spi_err <= csb_rise && !frame_ok;
            if (csb_rise && frame_ok) begin
                o_req_vld <= 1'b1;
            end else if (i_ack) begin
                o_req_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (csb_rise && frame_ok) begin
            o_req <= '{wr: frame_wr, addr: frame_addr, data: frame_data, crc: frame_crc};
        end
    end

    //==================================================
    // read response on miso
    //==================================================
    // sync delay is 3 cycles, below the half bit of an i_clk/8 sclk
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rsp_word <= '0;
            tx_sr    <= '0;
        end else begin
            if (i_ack && !o_req.wr) begin
                rsp_word <= {1'b0, o_req.addr, i_rsp.data, i_rsp.crc};
            end
            if (csb_q[1]) begin
                tx_sr <= rsp_word;  // first bit ready before csb falls
            end else if (sclk_fall) begin
                tx_sr <= {tx_sr[22:0], 1'b0};
            end
        end
    end

    assign o_spi_miso = tx_sr[23];

    a_req_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        o_req_vld && !i_ack |=> o_req_vld && $stable(o_req));

endmodule

`default_nettype wire

// ==== hdl/hv_reg_arb.sv ====
// Fixed-priority arbiter sharing the register bank between the SPI slave and the scanner
`default_nettype none

module hv_reg_arb import hv_reg_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_spi_vld,
    input  reg_req_t i_spi_req,
    output logic     o_spi_ack,
    input  logic     i_scan_vld,
    input  reg_req_t i_scan_req,
    output logic     o_scan_ack,
    output reg_rsp_t o_rsp,
    output logic     o_bank_vld,
    output reg_req_t o_bank_req,
    input  logic     i_bank_ack,
    input  reg_rsp_t i_bank_rsp
);

    logic pending;     // bank answer still owed
    logic winner_spi;

    // spi wins, one grant per bank answer
    assign o_bank_vld = !pending && (i_spi_vld || i_scan_vld);
    assign o_bank_req = i_spi_vld ? i_spi_req : i_scan_req;

    assign o_spi_ack  = i_bank_ack && winner_spi;
    assign o_scan_ack = i_bank_ack && !winner_spi;
    assign o_rsp      = i_bank_rsp;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pending    <= 1'b0;
            winner_spi <= 1'b0;
        end else if (o_bank_vld) begin
            pending    <= 1'b1;
            winner_spi <= i_spi_vld;
        end else if (i_bank_ack) begin
            pending    <= 1'b0;
        end
    end

    // each bank answer goes to exactly one peer that is still requesting
    a_ack_route: assert property (@(posedge i_clk) disable iff (i_reset)
        i_bank_ack |-> $onehot({o_spi_ack && i_spi_vld, o_scan_ack && i_scan_vld}));

endmodule

`default_nettype wire

// ==== hdl/hv_reg_bank.sv ====
// Register bank holding mode, configuration with stored CRCs and status, plus the interrupt
`default_nettype none

module hv_reg_bank import hv_reg_pkg::*; import hv_ctrl_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_vld,
    input  reg_req_t  i_req,
    output logic      o_ack,
    output reg_rsp_t  o_rsp,
    input  hv_fault_t i_fault_flt,
    input  logic      i_spi_err,
    input  logic      i_scan_crc_err,
    output hv_mode_t  o_mode,
    output hv_cfg_t   o_cfg,
    output logic      o_intb_n
);

    typedef logic [2:0] cfg_idx_t;

    reg_data_t cfg_data [NUM_CFG];
    reg_crc_t  cfg_crc  [NUM_CFG];
    hv_mode_t  mode_q;
    reg_data_t status1;
    reg_data_t status1_set;
    reg_data_t status1_clr;
    logic      is_cfg;
    cfg_idx_t  cfg_idx;
    reg_data_t rd_data;
    reg_crc_t  rd_crc;

    assign is_cfg  = (i_req.addr >= ADDR_CFG_FIRST) && (i_req.addr <= ADDR_CFG_LAST);
    assign cfg_idx = cfg_idx_t'(i_req.addr - ADDR_CFG_FIRST);

    //==================================================
    // mode and configuration storage
    //==================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_CFG; i++) begin
                cfg_data[i] <= '0;
                cfg_crc[i]  <= crc8({1'b1, ADDR_CFG_FIRST + reg_addr_t'(i), 8'h00});
            end
            mode_q <= '0;
        end else if (i_vld && i_req.wr) begin
            if (is_cfg) begin
                cfg_data[cfg_idx] <= i_req.data;
                cfg_crc[cfg_idx]  <= i_req.crc;  // kept as sent, checked by the scanner
            end
            if (i_req.addr == ADDR_MODE) begin
                mode_q.crc_bypass <= i_req.data[0];
            end
        end
    end

    //==================================================
    // status and interrupt
    //==================================================
    assign status1_set = {i_scan_crc_err, i_spi_err, i_fault_flt};
    assign status1_clr = (i_vld && i_req.wr && (i_req.addr == ADDR_STATUS1)) ? i_req.data : '0;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            status1  <= '0;
            o_intb_n <= 1'b1;
        end else begin
            status1  <= (status1 & ~status1_clr) | status1_set;  // set beats clear
            o_intb_n <= ~|status1;
        end
    end

    //==================================================
    // read path
    //==================================================
    always_comb begin
        rd_data = '0;
        if (is_cfg) begin
            rd_data = cfg_data[cfg_idx];
        end else begin
            case (i_req.addr)
                ADDR_MODE:    rd_data = mode_q;
                ADDR_STATUS1: rd_data = status1;
                ADDR_STATUS2: rd_data = {2'b00, i_fault_flt};
                default:      rd_data = '0;
            endcase
        end
        rd_crc = is_cfg ? cfg_crc[cfg_idx] : crc8({1'b1, i_req.addr, rd_data});
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ack <= 1'b0;
            o_cfg <= '0;
        end else begin
            o_ack <= i_vld;
            o_cfg <= {cfg_data[0], cfg_data[1], cfg_data[2],
                      cfg_data[3], cfg_data[4], cfg_data[5]};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_vld) begin
            o_rsp <= '{data: rd_data, crc: rd_crc};
        end
    end

    assign o_mode = mode_q;

endmodule

`default_nettype wire

// ==== hdl/hv_wdg_scan.sv ====
// Background scanner that rereads each configuration register and checks its stored CRC
`default_nettype none

module hv_wdg_scan import hv_reg_pkg::*; #(
    parameter int SCAN_PERIOD = 64
) (
    input  logic     i_clk,
    input  logic     i_reset,
    output logic     o_req_vld,
    output reg_req_t o_req,
    input  logic     i_ack,
    input  reg_rsp_t i_rsp,
    output logic     o_crc_err
);

    localparam int CNT_W = $clog2(SCAN_PERIOD);

    typedef logic [CNT_W-1:0] period_cnt_t;

    localparam period_cnt_t CNT_LAST = period_cnt_t'(SCAN_PERIOD - 1);

    period_cnt_t period_cnt;
    reg_addr_t   scan_addr;
    logic        crc_bad;

    assign o_req   = '{wr: 1'b0, addr: scan_addr, data: '0, crc: '0};
    assign crc_bad = (i_rsp.crc != crc8({1'b1, scan_addr, i_rsp.data}));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            period_cnt <= '0;
            scan_addr  <= ADDR_CFG_FIRST;
            o_req_vld  <= 1'b0;
            o_crc_err  <= 1'b0;
        end else begin
            o_crc_err <= i_ack && crc_bad;
            if (period_cnt == CNT_LAST) begin
                period_cnt <= '0;
            end else begin
                period_cnt <= period_cnt + period_cnt_t'(1);
            end
            if ((period_cnt == CNT_LAST) && !o_req_vld) begin
                o_req_vld <= 1'b1;
            end else if (i_ack) begin
                o_req_vld <= 1'b0;
            end
            if (i_ack) begin  // next register, wrap after the last one
                scan_addr <= (scan_addr == ADDR_CFG_LAST) ? ADDR_CFG_FIRST
                                                          : scan_addr + reg_addr_t'(1);
            end
        end
    end

    // the arbiter only answers a scan read that is outstanding
    a_ack_pending: assert property (@(posedge i_clk) disable iff (i_reset)
        i_ack |-> o_req_vld);

endmodule

`default_nettype wire

// ==== hdl/hv_fault_proc.sv ====
// Deglitch filters that qualify the six analog fault inputs before they reach the status bits
`default_nettype none

module hv_fault_proc import hv_ctrl_pkg::*; #(
    parameter int DEGLITCH_CYCLES = 4
) (
    input  logic      i_clk,
    input  logic      i_reset,
    input  hv_fault_t i_fault,
    output hv_fault_t o_fault_flt
);

    localparam int NUM_FAULT = $bits(hv_fault_t);
    localparam int CNT_W     = $clog2(DEGLITCH_CYCLES + 1);

    typedef logic [CNT_W-1:0] dgl_cnt_t;

    localparam dgl_cnt_t CNT_LIMIT = dgl_cnt_t'(DEGLITCH_CYCLES);

    dgl_cnt_t             dgl_cnt [NUM_FAULT];
    logic [NUM_FAULT-1:0] fault_vec;
    logic [NUM_FAULT-1:0] flt_vec;

    assign fault_vec = i_fault;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_FAULT; i++) begin
                dgl_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_FAULT; i++) begin
                if (!fault_vec[i]) begin
                    dgl_cnt[i] <= '0;  // any low sample restarts
                end else if (dgl_cnt[i] != CNT_LIMIT) begin
                    dgl_cnt[i] <= dgl_cnt[i] + dgl_cnt_t'(1);
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_FAULT; i++) begin
            flt_vec[i] = (dgl_cnt[i] == CNT_LIMIT);
        end
    end

    assign o_fault_flt = flt_vec;

endmodule

`default_nettype wire

// ==== hdl/hv_core.sv ====
// Top level of the HV die core connecting SPI slave, scanner, arbiter, register bank and faults
`default_nettype none

module hv_core import hv_reg_pkg::*; import hv_ctrl_pkg::*; #(
    parameter int SCAN_PERIOD     = 64,
    parameter int DEGLITCH_CYCLES = 4
) (
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_spi_sclk,
    input  logic      i_spi_csb,
    input  logic      i_spi_mosi,
    output logic      o_spi_miso,
    input  hv_fault_t i_fault,
    output hv_cfg_t   o_reg_cfg,
    output logic      o_intb_n
);

    hv_mode_t  reg_mode;
    logic      spi_req_vld;
    reg_req_t  spi_req;
    logic      spi_ack;
    logic      scan_req_vld;
    reg_req_t  scan_req;
    logic      scan_ack;
    reg_rsp_t  arb_rsp;      // shared by both peers, qualified by their ack
    logic      bank_vld;
    reg_req_t  bank_req;
    logic      bank_ack;
    reg_rsp_t  bank_rsp;
    logic      spi_err;
    logic      scan_crc_err;
    hv_fault_t fault_flt;

    hv_spi_slv u_spi_slv (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_spi_sclk (i_spi_sclk),
        .i_spi_csb  (i_spi_csb),
        .i_spi_mosi (i_spi_mosi),
        .o_spi_miso (o_spi_miso),
        .i_mode     (reg_mode),
        .o_req_vld  (spi_req_vld),
        .o_req      (spi_req),
        .i_ack      (spi_ack),
        .i_rsp      (arb_rsp),
        .o_spi_err  (spi_err)
    );

    hv_wdg_scan #(.SCAN_PERIOD(SCAN_PERIOD)) u_wdg_scan (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .o_req_vld  (scan_req_vld),
        .o_req      (scan_req),
        .i_ack      (scan_ack),
        .i_rsp      (arb_rsp),
        .o_crc_err  (scan_crc_err)
    );

    hv_reg_arb u_reg_arb (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_spi_vld  (spi_req_vld),
        .i_spi_req  (spi_req),
        .o_spi_ack  (spi_ack),
        .i_scan_vld (scan_req_vld),
        .i_scan_req (scan_req),
        .o_scan_ack (scan_ack),
        .o_rsp      (arb_rsp),
        .o_bank_vld (bank_vld),
        .o_bank_req (bank_req),
        .i_bank_ack (bank_ack),
        .i_bank_rsp (bank_rsp)
    );

    hv_reg_bank u_reg_bank (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_vld          (bank_vld),
        .i_req          (bank_req),
        .o_ack          (bank_ack),
        .o_rsp          (bank_rsp),
        .i_fault_flt    (fault_flt),
        .i_spi_err      (spi_err),
        .i_scan_crc_err (scan_crc_err),
        .o_mode         (reg_mode),
        .o_cfg          (o_reg_cfg),
        .o_intb_n       (o_intb_n)
    );

    hv_fault_proc #(.DEGLITCH_CYCLES(DEGLITCH_CYCLES)) u_fault_proc (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_fault     (i_fault),
        .o_fault_flt (fault_flt)
    );

endmodule

`default_nettype wire

// ==== dv/hv_core_tb.sv ====
// Directed testbench for the HV core; drives SPI frames and fault inputs, checks bank behavior
`default_nettype none

module hv_core_tb import hv_reg_pkg::*; import hv_ctrl_pkg::*; ();

    localparam int SCAN_PERIOD     = 64;
    localparam int DEGLITCH_CYCLES = 4;
    localparam int SCAN_TIMEOUT    = 6 * SCAN_PERIOD + 20;

    logic      clk;
    logic      reset;
    logic      spi_sclk;
    logic      spi_csb;
    logic      spi_mosi;
    logic      spi_miso;
    hv_fault_t fault;
    hv_cfg_t   reg_cfg;
    logic      intb_n;

    string     test_name;
    int        error_count;
    logic      intb_watch;                 // flags writes that must not interrupt
    reg_data_t exp_data [1:6];
    reg_crc_t  exp_crc  [1:6];

    hv_core #(
        .SCAN_PERIOD     (SCAN_PERIOD),
        .DEGLITCH_CYCLES (DEGLITCH_CYCLES)
    ) uut (
        .i_clk      (clk),
        .i_reset    (reset),
        .i_spi_sclk (spi_sclk),
        .i_spi_csb  (spi_csb),
        .i_spi_mosi (spi_mosi),
        .o_spi_miso (spi_miso),
        .i_fault    (fault),
        .o_reg_cfg  (reg_cfg),
        .o_intb_n   (intb_n)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //==================================================
    // reporting and checks
    //==================================================
    task automatic report_mismatch(input string what, input string exp_s, input string act_s);
        error_count++;
        $display("[ERROR] %s: %s expected %s actual %s", test_name, what, exp_s, act_s);
        $display("Errors found");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout in test %s: %s did not happen in time", test_name, what);
        $display("Errors found");
        $fatal(1, "stopping on timeout");
    endtask

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        assert (act === exp) else
            report_mismatch(what, $sformatf("0x%02h", exp), $sformatf("0x%02h", act));
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        assert (act === exp) else
            report_mismatch(what, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    always @(negedge clk) begin
        if (intb_watch) begin
            check_bit("o_intb_n during config writes", 1'b1, intb_n);
        end
    end

    //==================================================
    // reference model and bus helpers
    //==================================================
    // msb-first crc-8 with poly 0x07 and zero init
    function automatic logic [7:0] calc_crc(input logic [15:0] bits);
        logic [7:0] c;
        logic       fb;
        c = 8'h00;
        for (int i = 15; i >= 0; i--) begin
            fb = c[7] ^ bits[i];
            c  = c << 1;
            if (fb) begin
                c = c ^ 8'h07;
            end
        end
        return c;
    endfunction

    function automatic logic [7:0] cfg_field(input hv_cfg_t cfg, input int addr);
        case (addr)
            1:       return cfg.src_sel;
            2:       return cfg.snk_sel;
            3:       return cfg.desat_sel;
            4:       return cfg.oc_sel;
            5:       return cfg.sc_sel;
            6:       return cfg.dvdt_sel;
            default: return 8'h00;
        endcase
    endfunction

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;  // inputs change just after the edge
    endtask

    task automatic wait_intb(input logic level, input int max_cycles, input string what);
        int n;
        n = 0;
        while (intb_n !== level) begin
            if (n >= max_cycles) begin
                abort_on_timeout(what);
            end
            step(1);
            n++;
        end
    endtask

    // mode 0 at clk/8 with miso sampled before each rising sclk
    task automatic spi_frame(input logic [23:0] tx_word, output logic [23:0] rx_word);
        rx_word = '0;
        spi_csb = 1'b0;
        for (int i = 23; i >= 0; i--) begin
            spi_mosi = tx_word[i];
            step(4);
            rx_word[i] = spi_miso;
            spi_sclk   = 1'b1;
            step(4);
            spi_sclk   = 1'b0;
        end
        step(4);
        spi_csb  = 1'b1;
        spi_mosi = 1'b0;
        step(12);
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data, input reg_crc_t flip);
        logic [23:0] rx;
        spi_frame({1'b1, addr, data, calc_crc({1'b1, addr, data}) ^ flip}, rx);
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t data, output reg_crc_t crc);
        logic [23:0] cmd;
        logic [23:0] rx;
        cmd = {1'b0, addr, 8'h00, calc_crc({1'b0, addr, 8'h00})};
        spi_frame(cmd, rx);
        spi_frame(cmd, rx);  // answer to the first frame
        check_bit("miso lead bit", 1'b0, rx[23]);
        check_byte("miso address", {1'b0, addr}, {1'b0, rx[22:16]});
        data = rx[15:8];
        crc  = rx[7:0];
    endtask

    task automatic check_reg(input reg_addr_t addr, input reg_data_t data, input reg_crc_t crc);
        reg_data_t rd_data;
        reg_crc_t  rd_crc;
        read_reg(addr, rd_data, rd_crc);
        check_byte($sformatf("data at 0x%02h", addr), data, rd_data);
        check_byte($sformatf("crc at 0x%02h", addr), crc, rd_crc);
    endtask

    task automatic check_status(input reg_addr_t addr, input reg_data_t data);
        check_reg(addr, data, calc_crc({1'b1, addr, data}));
    endtask

    //==================================================
    // directed tests
    //==================================================
    task automatic test_reset_values();
        test_name = "reset_values";
        check_bit("o_spi_miso", 1'b0, spi_miso);
        check_bit("o_intb_n", 1'b1, intb_n);
        for (int a = 1; a <= 6; a++) begin
            exp_data[a] = 8'h00;
            exp_crc[a]  = calc_crc({1'b1, reg_addr_t'(a), 8'h00});
            check_byte($sformatf("o_reg_cfg field %0d", a), 8'h00, cfg_field(reg_cfg, a));
            check_reg(reg_addr_t'(a), exp_data[a], exp_crc[a]);
        end
    endtask

    task automatic test_cfg_write_read();
        reg_data_t d;
        test_name  = "cfg_write_read";
        intb_watch = 1'b1;
        for (int a = 1; a <= 6; a++) begin
            d = 8'($urandom);
            write_reg(reg_addr_t'(a), d, 8'h00);
            exp_data[a] = d;
            exp_crc[a]  = calc_crc({1'b1, reg_addr_t'(a), d});
        end
        for (int a = 1; a <= 6; a++) begin
            check_reg(reg_addr_t'(a), exp_data[a], exp_crc[a]);
            check_byte($sformatf("o_reg_cfg field %0d", a), exp_data[a], cfg_field(reg_cfg, a));
        end
        intb_watch = 1'b0;
    endtask

    task automatic test_bad_crc_write();
        test_name = "bad_crc_write";
        write_reg(7'h02, exp_data[2] ^ 8'h5A, 8'h01);
        wait_intb(1'b0, 20, "o_intb_n falling after bad crc");
        check_reg(7'h02, exp_data[2], exp_crc[2]);
        check_status(ADDR_STATUS1, 8'h40);
        write_reg(ADDR_STATUS1, 8'h40, 8'h00);
        wait_intb(1'b1, 20, "o_intb_n rising after status clear");
        check_status(ADDR_STATUS1, 8'h00);
    endtask

    task automatic test_fault_deglitch();
        hv_fault_t one;
        logic [5:0] mix;
        reg_data_t  st;
        reg_crc_t   crc;
        test_name = "fault_deglitch";
        one       = '0;
        one.ot    = 1'b1;
        fault = one;
        step(3);  // shorter than the filter
        fault = '0;
        step(20);
        check_bit("o_intb_n after short glitch", 1'b1, intb_n);
        check_status(ADDR_STATUS1, 8'h00);
        fault = one;
        step(10);
        check_bit("o_intb_n with fault held", 1'b0, intb_n);
        check_status(ADDR_STATUS2, {2'b00, one});
        fault = '0;
        step(5);
        check_status(ADDR_STATUS2, 8'h00);
        check_status(ADDR_STATUS1, {2'b00, one});
        write_reg(ADDR_STATUS1, {2'b00, one}, 8'h00);
        wait_intb(1'b1, 20, "o_intb_n rising after fault clear");

        mix   = 6'($urandom % 63) + 6'd1;
        fault = mix;
        step(10);
        read_reg(ADDR_STATUS2, st, crc);
        check_byte("STATUS2 crc", calc_crc({1'b1, ADDR_STATUS2, 2'b00, mix}), crc);
        for (int b = 0; b < 6; b++) begin
            check_bit($sformatf("STATUS2 bit %0d", b), mix[b], st[b]);
        end
        fault = '0;
        step(5);
        read_reg(ADDR_STATUS1, st, crc);
        for (int b = 0; b < 6; b++) begin
            check_bit($sformatf("STATUS1 bit %0d", b), mix[b], st[b]);
        end
        check_bit("STATUS1 bit 6", 1'b0, st[6]);
        check_bit("STATUS1 bit 7", 1'b0, st[7]);
        write_reg(ADDR_STATUS1, 8'h3F, 8'h00);
        wait_intb(1'b1, 20, "o_intb_n rising after fault mix clear");
    endtask

    task automatic test_crc_scan();
        reg_data_t d;
        reg_crc_t  bad;
        test_name = "crc_scan";
        write_reg(ADDR_MODE, 8'h01, 8'h00);  // crc_bypass on
        check_status(ADDR_MODE, 8'h01);
        d   = 8'($urandom);
        bad = calc_crc({1'b1, 7'h04, d}) ^ 8'h3C;
        write_reg(7'h04, d, 8'h3C);
        exp_data[4] = d;
        exp_crc[4]  = bad;
        wait_intb(1'b0, SCAN_TIMEOUT, "scanner crc error interrupt");
        check_status(ADDR_STATUS1, 8'h80);
        check_reg(7'h04, exp_data[4], exp_crc[4]);
        check_byte("o_reg_cfg field 4", exp_data[4], cfg_field(reg_cfg, 4));
        check_reg(7'h01, exp_data[1], exp_crc[1]);
        check_reg(7'h06, exp_data[6], exp_crc[6]);
    endtask

    //==================================================
    // main sequence
    //==================================================
    initial begin
        error_count = 0;
        intb_watch  = 1'b0;
        test_name   = "init";
        reset       = 1'b1;
        spi_sclk    = 1'b0;
        spi_csb     = 1'b1;
        spi_mosi    = 1'b0;
        fault       = '0;
        void'($urandom(51210));
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        step(4);

        test_reset_values();
        test_cfg_write_read();
        test_bad_crc_write();
        test_fault_deglitch();
        test_crc_scan();

        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hv_core.f ====
hdl/hv_reg_pkg.sv
hdl/hv_ctrl_pkg.sv
hdl/hv_spi_slv.sv
hdl/hv_reg_arb.sv
hdl/hv_reg_bank.sv
hdl/hv_wdg_scan.sv
hdl/hv_fault_proc.sv
hdl/hv_core.sv
dv/hv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module hv_core_tb -f hv_core.f -o hv_core_sim

./obj_dir/hv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "simulation did not complete"
    exit 1
fi
echo "simulation passed"
